/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_decode_stage
FILELIST  := list.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hw/control_unit.sv */
`timescale 1ns/1ps

module control_unit
    import core_pkg::*;
(
    input  opcode_e    opcode,
    input  logic [2:0] funct3,
    input  logic [6:0] funct7,
    output logic       memtoreg,
    output logic       memwrite,
    output logic       memread,
    output logic       imemwrite,
    output logic       branchjump,
    output logic       regwrite,
    output logic       aluorfpu,
    output alu_op_e    aluop,
    output fpu_op_e    fpuop,
    output src_sel_e   src0,
    output src_sel_e   src1,
    output logic       rs0flag,
    output logic       rs1flag,
    output logic       rdflag
);

    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  arith_op = alt ? SUB : ADD;
            3'b001:  arith_op = SLL;
            3'b010:  arith_op = SLT;
            3'b011:  arith_op = SLTU;
            3'b100:  arith_op = XOR;
            3'b101:  arith_op = alt ? SRA : SRL;
            3'b110:  arith_op = OR;
            default: arith_op = AND;
        endcase
    endfunction

    always_comb begin
        memtoreg   = 1'b0;
        memwrite   = 1'b0;
        memread    = 1'b0;
        imemwrite  = 1'b0;
        branchjump = 1'b0;
        regwrite   = 1'b0;
        aluorfpu   = 1'b0;
        aluop      = ADD;
        fpuop      = FNONE;
        src0       = REG;
        src1       = REG;
        rs0flag    = 1'b0;
        rs1flag    = 1'b0;
        rdflag     = 1'b0;
        case (opcode)
            LOAD, LOAD_FP: begin
                memread  = 1'b1;
                memtoreg = 1'b1;
                regwrite = 1'b1;
                src1     = IMM;
                rdflag   = (opcode == LOAD_FP);
            end
            STORE, STORE_FP: begin
                memwrite = 1'b1;
                src1     = IMM;
                rs1flag  = (opcode == STORE_FP);
            end
            IMEM_STORE: begin
                imemwrite = 1'b1;
                src1      = IMM;
            end
            OP: begin
                regwrite = 1'b1;
                aluop    = arith_op(funct3, funct7[5]);
            end
            OP_IMM: begin
                regwrite = 1'b1;
                src1     = IMM;
                aluop    = arith_op(funct3, funct3 == 3'b101 && funct7[5]); // Only SRAI.
            end
            BRANCH: begin
                branchjump = 1'b1;
                case (funct3)
                    3'b001:  aluop = NE;
                    3'b100:  aluop = LT;
                    3'b101:  aluop = GE;
                    3'b110:  aluop = LTU;
                    3'b111:  aluop = GEU;
                    default: aluop = EQ;
                endcase
            end
            JAL, JALR: begin
                branchjump = 1'b1;
                regwrite   = 1'b1;
                src0       = (opcode == JAL) ? PC : REG;
                src1       = IMM;
            end
            LUI, AUIPC: begin
                regwrite = 1'b1;
                src0     = (opcode == LUI) ? ZERO : PC;
                src1     = IMM;
            end
            OP_FP: begin
                regwrite = 1'b1;
                aluorfpu = 1'b1;
                rs0flag  = 1'b1;
                rs1flag  = 1'b1;
                rdflag   = 1'b1;
                case (funct7[6:2])
                    5'b00000: fpuop = FADD;
                    5'b00001: fpuop = FSUB;
                    5'b00010: fpuop = FMUL;
                    5'b00011: fpuop = FDIV;
                    5'b01011: fpuop = FSQRT;
                    5'b10100: begin
                        fpuop  = FCMP;
                        rdflag = 1'b0;  // Compare writes an integer register.
                    end
                    5'b11100: begin
                        fpuop  = FMV;
                        rdflag = 1'b0;  // Move to integer.
                    end
                    5'b11110: fpuop = FMV;
                    default:  fpuop = FNONE;
                endcase
            end
            default: ;
        endcase
    end

endmodule

/* hw/core_pkg.sv */
package core_pkg;

    // Major opcodes, bits [6:0] of the instruction.
    typedef enum logic [6:0] {
        LOAD       = 7'b0000011,
        STORE      = 7'b0100011,
        OP         = 7'b0110011,
        OP_IMM     = 7'b0010011,
        BRANCH     = 7'b1100011,
        JAL        = 7'b1101111,
        JALR       = 7'b1100111,
        LUI        = 7'b0110111,
        AUIPC      = 7'b0010111,
        LOAD_FP    = 7'b0000111,
        STORE_FP   = 7'b0100111,
        OP_FP      = 7'b1010011,
        IMEM_STORE = 7'b0001011   // custom-0, store into instruction memory.
    } opcode_e;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        EQ, NE, LT, GE, LTU, GEU  // Branch compares.
    } alu_op_e;

    // FNONE is zero so that an unknown opcode decodes to all-zero control.
    typedef enum logic [2:0] {
        FNONE, FADD, FSUB, FMUL, FDIV, FSQRT, FMV, FCMP
    } fpu_op_e;

    typedef enum logic [1:0] {
        REG, IMM, PC, ZERO
    } src_sel_e;

    typedef enum logic [1:0] {
        FWD_RF, FWD_EX, FWD_MEM
    } fwd_sel_e;

    // Result offered for forwarding by a later stage.
    typedef struct packed {
        logic        regwrite;
        logic [5:0]  rd;
        logic [31:0] data;
    } fwd_src_t;

    typedef struct packed {
        logic        memtoreg;
        logic        memwrite;
        logic        memread;
        logic        imemwrite;
        logic        branchjump;
        logic        regwrite;
        logic        aluorfpu;    // Set when the FPU produces the result.
        alu_op_e     aluop;
        fpu_op_e     fpuop;
        src_sel_e    src0;
        src_sel_e    src1;
        logic [5:0]  rs0;
        logic [5:0]  rs1;
        logic [5:0]  rd;
        logic [31:0] imm;
        logic [31:0] pc;
    } inst_t;

endpackage

/* hw/decode.sv */
`timescale 1ns/1ps

module decode
    import core_pkg::*;
(
    input  logic [31:0] pc,
    input  logic [31:0] instr,
    input  logic [31:0] rs0data,
    input  logic [31:0] rs1data,
    input  logic [31:0] ex_data,
    input  logic [31:0] mem_data,
    input  fwd_sel_e    forward0,
    input  fwd_sel_e    forward1,
    output logic [5:0]  rs0,
    output logic [5:0]  rs1,
    output inst_t       inst,
    output logic [31:0] rdata0,
    output logic [31:0] rdata1
);

    opcode_e     opcode;
    logic        memtoreg;
    logic        memwrite;
    logic        memread;
    logic        imemwrite;
    logic        branchjump;
    logic        regwrite;
    logic        aluorfpu;
    alu_op_e     aluop;
    fpu_op_e     fpuop;
    src_sel_e    src0;
    src_sel_e    src1;
    logic        rs0flag;
    logic        rs1flag;
    logic        rdflag;
    logic [31:0] imm;

    function automatic logic [31:0] operand(input fwd_sel_e sel,
                                            input logic [31:0] rf,
                                            input logic [31:0] ex,
                                            input logic [31:0] mem);
        case (sel)
            FWD_RF:  operand = rf;
            FWD_EX:  operand = ex;
            FWD_MEM: operand = mem;
            default: operand = 32'd0;
        endcase
    endfunction

    assign opcode = opcode_e'(instr[6:0]);

    control_unit u_control_unit (
        .opcode     (opcode),
        .funct3     (instr[14:12]),
        .funct7     (instr[31:25]),
        .memtoreg   (memtoreg),
        .memwrite   (memwrite),
        .memread    (memread),
        .imemwrite  (imemwrite),
        .branchjump (branchjump),
        .regwrite   (regwrite),
        .aluorfpu   (aluorfpu),
        .aluop      (aluop),
        .fpuop      (fpuop),
        .src0       (src0),
        .src1       (src1),
        .rs0flag    (rs0flag),
        .rs1flag    (rs1flag),
        .rdflag     (rdflag)
    );

    imm_gen u_imm_gen (
        .instr (instr),
        .imm   (imm)
    );

    // Bank flag on top of the 5-bit register number.
    assign rs0 = {rs0flag, instr[19:15]};
    assign rs1 = {rs1flag, instr[24:20]};

    always_comb begin
        inst.memtoreg   = memtoreg;
        inst.memwrite   = memwrite;
        inst.memread    = memread;
        inst.imemwrite  = imemwrite;
        inst.branchjump = branchjump;
        inst.regwrite   = regwrite;
        inst.aluorfpu   = aluorfpu;
        inst.aluop      = aluop;
        inst.fpuop      = fpuop;
        inst.src0       = src0;
        inst.src1       = src1;
        inst.rs0        = rs0;
        inst.rs1        = rs1;
        inst.rd         = {rdflag, instr[11:7]};
        inst.imm        = imm;
        inst.pc         = pc;
    end

    assign rdata0 = operand(forward0, rs0data, ex_data, mem_data);
    assign rdata1 = operand(forward1, rs1data, ex_data, mem_data);

endmodule

/* hw/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage
    import core_pkg::*;
#(
    parameter int NREGS = 64
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        enable,
    input  logic [31:0] pc,
    input  logic [31:0] instr,
    input  logic        wb_en,
    input  logic [5:0]  wb_rd,
    input  logic [31:0] wb_data,
    input  fwd_src_t    ex_src,
    input  fwd_src_t    mem_src,
    output inst_t       inst_q,
    output logic [31:0] rdata0_q,
    output logic [31:0] rdata1_q,
    output logic        valid_q
);

    logic [5:0]  rs0;
    logic [5:0]  rs1;
    logic [31:0] rs0data;
    logic [31:0] rs1data;
    fwd_sel_e    forward0;
    fwd_sel_e    forward1;
    inst_t       inst;
    logic [31:0] rdata0;
    logic [31:0] rdata1;

    reg_file #(
        .NREGS (NREGS)
    ) u_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs0     (rs0),
        .rs1     (rs1),
        .wb_en   (wb_en),
        .wb_rd   (wb_rd),
        .wb_data (wb_data),
        .rs0data (rs0data),
        .rs1data (rs1data)
    );

    forward_unit u_forward_unit (
        .rs0      (rs0),
        .rs1      (rs1),
        .ex_src   (ex_src),
        .mem_src  (mem_src),
        .forward0 (forward0),
        .forward1 (forward1)
    );

    decode u_decode (
        .pc       (pc),
        .instr    (instr),
        .rs0data  (rs0data),
        .rs1data  (rs1data),
        .ex_data  (ex_src.data),
        .mem_data (mem_src.data),
        .forward0 (forward0),
        .forward1 (forward1),
        .rs0      (rs0),
        .rs1      (rs1),
        .inst     (inst),
        .rdata0   (rdata0),
        .rdata1   (rdata1)
    );

    // ID/EX register.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            inst_q  <= '0;
        end else begin
            valid_q <= enable;  // One-cycle pulse per enabled edge.
            if (enable) begin
                inst_q <= inst;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            rdata0_q <= rdata0;
            rdata1_q <= rdata1;
        end
    end

endmodule

/* hw/forward_unit.sv */
`timescale 1ns/1ps

module forward_unit
    import core_pkg::*;
(
    input  logic [5:0] rs0,
    input  logic [5:0] rs1,
    input  fwd_src_t   ex_src,
    input  fwd_src_t   mem_src,
    output fwd_sel_e   forward0,
    output fwd_sel_e   forward1
);

    // Execute result is newer than the memory result, so it wins.
    function automatic fwd_sel_e pick(input logic [5:0] rs,
                                      input fwd_src_t ex,
                                      input fwd_src_t mem);
        if (rs == 6'd0) begin
            pick = FWD_RF;  // Integer x0 is hard zero.
        end else if (ex.regwrite && ex.rd == rs) begin
            pick = FWD_EX;
        end else if (mem.regwrite && mem.rd == rs) begin
            pick = FWD_MEM;
        end else begin
            pick = FWD_RF;
        end
    endfunction

    assign forward0 = pick(rs0, ex_src, mem_src);
    assign forward1 = pick(rs1, ex_src, mem_src);

endmodule

/* hw/imm_gen.sv */
`timescale 1ns/1ps

module imm_gen
    import core_pkg::*;
(
    input  logic [31:0] instr,
    output logic [31:0] imm
);

    opcode_e opcode;

    assign opcode = opcode_e'(instr[6:0]);

    always_comb begin
        case (opcode)
            LOAD, LOAD_FP, OP_IMM, JALR:
                imm = {{20{instr[31]}}, instr[31:20]};
            STORE, STORE_FP, IMEM_STORE:
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            BRANCH:
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            LUI, AUIPC:
                imm = {instr[31:12], 12'd0};
            JAL:
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            default:
                imm = 32'd0;    // R-type and unknown.
        endcase
    end

endmodule

/* hw/reg_file.sv */
`timescale 1ns/1ps

module reg_file #(
    parameter int NREGS = 64
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [5:0]  rs0,
    input  logic [5:0]  rs1,
    input  logic        wb_en,
    input  logic [5:0]  wb_rd,
    input  logic [31:0] wb_data,
    output logic [31:0] rs0data,
    output logic [31:0] rs1data
);

    // Index 0 to 31 integer bank, 32 to 63 float bank.
    logic [31:0] regs [NREGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (wb_en && wb_rd != 6'd0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // Reads see the value before a same-cycle write.
    assign rs0data = (rs0 == 6'd0) ? 32'd0 : regs[rs0];
    assign rs1data = (rs1 == 6'd0) ? 32'd0 : regs[rs1];

endmodule

/* list.f */
hw/core_pkg.sv
hw/control_unit.sv
hw/imm_gen.sv
hw/reg_file.sv
hw/forward_unit.sv
hw/decode.sv
hw/decode_stage.sv
sim/tb_decode_assert.sv
sim/tb_decode_stage.sv

/* sim/tb_decode_assert.sv */
`timescale 1ns/1ps

module tb_decode_assert
    import core_pkg::*;
(
    input logic  clk,
    input logic  rst_n,
    input logic  enable,
    input logic  valid_q,
    input inst_t inst_q
);

    int unsigned fail_count = 0;
    logic        seen_valid;   // Set once the first record has been loaded.
    logic [6:0]  ctrl;

    assign ctrl = {inst_q.memtoreg, inst_q.memwrite, inst_q.memread, inst_q.imemwrite,
                   inst_q.branchjump, inst_q.regwrite, inst_q.aluorfpu};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            seen_valid <= 1'b0;
        end else if (valid_q) begin
            seen_valid <= 1'b1;
        end
    end

    a_reset_valid: assert property (@(posedge clk) !rst_n |=> !valid_q)
        else begin $error("valid_q set during reset"); fail_count++; end

    a_valid_follows: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> valid_q == $past(enable))
        else begin $error("valid_q does not follow enable"); fail_count++; end

    a_hold_record: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) && !$past(enable) |-> $stable(inst_q))
        else begin $error("inst_q changed while enable was low"); fail_count++; end

    a_idle_control: assert property (@(posedge clk) disable iff (!rst_n)
        !seen_valid && !valid_q |-> ctrl == 7'd0)
        else begin $error("control bit set before first valid record"); fail_count++; end

endmodule

bind decode_stage tb_decode_assert u_decode_assert (
    .clk     (clk),
    .rst_n   (rst_n),
    .enable  (enable),
    .valid_q (valid_q),
    .inst_q  (inst_q)
);

/* sim/tb_decode_stage.sv */
`timescale 1ns/1ps

module tb_decode_stage
    import core_pkg::*;
();

    localparam int CLK_PERIOD = 8;
    localparam int N_WRITES   = 24;
    localparam int N_RANDOM   = 200;
    localparam int N_FWD      = 200;
    localparam int N_HOLD     = 8;
    localparam int N_CYCLES   = 16 + 2 + 2 + N_WRITES + 2 * N_RANDOM + 2 * N_FWD + N_HOLD + 8;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        enable;
    logic [31:0] pc;
    logic [31:0] instr;
    logic        wb_en;
    logic [5:0]  wb_rd;
    logic [31:0] wb_data;
    fwd_src_t    ex_src;
    fwd_src_t    mem_src;
    inst_t       inst_q;
    logic [31:0] rdata0_q;
    logic [31:0] rdata1_q;
    logic        valid_q;

    logic [31:0] lcg_state = 32'h52e3_6c5a;
    logic [31:0] shadow [64];   // Model of the register file contents.
    inst_t       exp_inst;
    logic [31:0] exp_rd0;
    logic [31:0] exp_rd1;

    // Three unknown opcodes at the end.
    logic [6:0] opcode_tbl [16] = '{LOAD, STORE, OP, OP_IMM, BRANCH, JAL, JALR, LUI, AUIPC,
                                    LOAD_FP, STORE_FP, OP_FP, IMEM_STORE,
                                    7'h7f, 7'h00, 7'h73};
    logic [4:0] fp_funct5_tbl [8] = '{5'b00000, 5'b00001, 5'b00010, 5'b00011,
                                      5'b01011, 5'b10100, 5'b11100, 5'b11110};
    alu_op_e    arith_tbl [8] = '{ADD, SLL, SLT, SLTU, XOR, SRL, OR, AND};
    alu_op_e    branch_tbl [8] = '{EQ, NE, EQ, EQ, LT, GE, LTU, GEU};

    decode_stage #(
        .NREGS (64)
    ) u_decode_stage (
        .clk      (clk),
        .rst_n    (rst_n),
        .enable   (enable),
        .pc       (pc),
        .instr    (instr),
        .wb_en    (wb_en),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .ex_src   (ex_src),
        .mem_src  (mem_src),
        .inst_q   (inst_q),
        .rdata0_q (rdata0_q),
        .rdata1_q (rdata1_q),
        .valid_q  (valid_q)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] random_instr();
        logic [31:0] r;
        logic [31:0] sel;
        r = next_rand();
        sel = next_rand();
        r[6:0] = opcode_tbl[sel[19:16]];
        if (r[6:0] == OP_FP) begin
            r[31:27] = fp_funct5_tbl[sel[23:21]];
        end
        return r;
    endfunction

    function automatic fwd_src_t make_fwd_src(input logic we, input logic [5:0] rd);
        fwd_src_t f;
        f.regwrite = we;
        f.rd = rd;
        f.data = next_rand();
        return f;
    endfunction

    function automatic alu_op_e arith(input logic [2:0] f3, input logic alt);
        if (alt && f3 == 3'b000) return SUB;
        if (alt && f3 == 3'b101) return SRA;
        return arith_tbl[f3];
    endfunction

    function automatic logic [31:0] expect_imm(input logic [31:0] ins);
        case (ins[6:0])
            LOAD, LOAD_FP, OP_IMM, JALR: return 32'($signed(ins[31:20]));
            STORE, STORE_FP, IMEM_STORE: return 32'($signed({ins[31:25], ins[11:7]}));
            BRANCH: return 32'($signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}));
            LUI, AUIPC: return {ins[31:12], 12'h000};
            JAL: return 32'($signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}));
            default: return 32'h0;
        endcase
    endfunction

    function automatic inst_t expect_inst(input logic [31:0] ins, input logic [31:0] pc_v);
        inst_t e;
        logic  fs0;
        logic  fs1;
        logic  fd;
        e = '0;
        fs0 = 1'b0;
        fs1 = 1'b0;
        fd = 1'b0;
        case (ins[6:0])
            LOAD, LOAD_FP: begin
                {e.memread, e.memtoreg, e.regwrite} = 3'b111;
                e.src1 = IMM;
                fd = ins[2];   // FP variant differs in bit 2.
            end
            STORE, STORE_FP: begin
                e.memwrite = 1'b1;
                e.src1 = IMM;
                fs1 = ins[2];
            end
            IMEM_STORE: begin
                e.imemwrite = 1'b1;
                e.src1 = IMM;
            end
            OP: begin
                e.regwrite = 1'b1;
                e.aluop = arith(ins[14:12], ins[30]);
            end
            OP_IMM: begin
                e.regwrite = 1'b1;
                e.src1 = IMM;
                e.aluop = arith(ins[14:12], ins[30] && ins[14:12] == 3'b101);
            end
            BRANCH: begin
                e.branchjump = 1'b1;
                e.aluop = branch_tbl[ins[14:12]];
            end
            JAL, JALR: begin
                {e.branchjump, e.regwrite} = 2'b11;
                e.src0 = ins[3] ? PC : REG;
                e.src1 = IMM;
            end
            LUI, AUIPC: begin
                e.regwrite = 1'b1;
                e.src0 = ins[5] ? ZERO : PC;
                e.src1 = IMM;
            end
            OP_FP: begin
                {e.regwrite, e.aluorfpu, fs0, fs1} = 4'b1111;
                fd = !(ins[31:27] inside {5'b10100, 5'b11100});  // Integer result.
                case (ins[31:27])
                    5'b00000: e.fpuop = FADD;
                    5'b00001: e.fpuop = FSUB;
                    5'b00010: e.fpuop = FMUL;
                    5'b00011: e.fpuop = FDIV;
                    5'b01011: e.fpuop = FSQRT;
                    5'b10100: e.fpuop = FCMP;
                    5'b11100, 5'b11110: e.fpuop = FMV;
                    default: e.fpuop = FNONE;
                endcase
            end
            default: ;
        endcase
        e.rs0 = {fs0, ins[19:15]};
        e.rs1 = {fs1, ins[24:20]};
        e.rd = {fd, ins[11:7]};
        e.imm = expect_imm(ins);
        e.pc = pc_v;
        return e;
    endfunction

    // Forwarded data beats the register file, execute beats memory, x0 stays zero.
    function automatic logic [31:0] expect_operand(input logic [5:0] idx,
                                                   input fwd_src_t ex, input fwd_src_t mem);
        if (idx == 6'd0) return 32'd0;
        if (ex.regwrite && ex.rd == idx) return ex.data;
        if (mem.regwrite && mem.rd == idx) return mem.data;
        return shadow[idx];
    endfunction

    function automatic logic [6:0] ctrl_bits(input inst_t i);
        return {i.memtoreg, i.memwrite, i.memread, i.imemwrite,
                i.branchjump, i.regwrite, i.aluorfpu};
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("Mismatch at %0t: %s expected 0x%h, got 0x%h", $time, name, exp, act);
            $display("Result: FAILED");
            $fatal(1, "output check failed");
        end
    endtask

    task automatic check_outputs(input logic valid_exp);
        check_val("valid_q", 32'(valid_exp), 32'(valid_q));
        check_val("inst_q control bits", 32'(ctrl_bits(exp_inst)), 32'(ctrl_bits(inst_q)));
        check_val("inst_q.aluop", 32'(exp_inst.aluop), 32'(inst_q.aluop));
        check_val("inst_q.fpuop", 32'(exp_inst.fpuop), 32'(inst_q.fpuop));
        check_val("inst_q.src0", 32'(exp_inst.src0), 32'(inst_q.src0));
        check_val("inst_q.src1", 32'(exp_inst.src1), 32'(inst_q.src1));
        check_val("inst_q.rs0", 32'(exp_inst.rs0), 32'(inst_q.rs0));
        check_val("inst_q.rs1", 32'(exp_inst.rs1), 32'(inst_q.rs1));
        check_val("inst_q.rd", 32'(exp_inst.rd), 32'(inst_q.rd));
        check_val("inst_q.imm", exp_inst.imm, inst_q.imm);
        check_val("inst_q.pc", exp_inst.pc, inst_q.pc);
        check_val("rdata0_q", exp_rd0, rdata0_q);
        check_val("rdata1_q", exp_rd1, rdata1_q);
    endtask

    task automatic write_reg(input logic [5:0] idx, input logic [31:0] data);
        enable = 1'b0;
        wb_en = 1'b1;
        wb_rd = idx;
        wb_data = data;
        @(negedge clk);
        wb_en = 1'b0;
        if (idx != 6'd0) begin
            shadow[idx] = data;
        end
    endtask

    task automatic apply_vector(input logic [31:0] ins, input logic [31:0] pc_v,
                                input fwd_src_t ex, input fwd_src_t mem);
        instr = ins;
        pc = pc_v;
        ex_src = ex;
        mem_src = mem;
        enable = 1'b1;
        exp_inst = expect_inst(ins, pc_v);
        exp_rd0 = expect_operand(exp_inst.rs0, ex, mem);
        exp_rd1 = expect_operand(exp_inst.rs1, ex, mem);
        @(negedge clk);
        check_outputs(1'b1);
    endtask

    // New inputs with enable low must leave the stage register untouched.
    task automatic hold_cycle();
        enable = 1'b0;
        instr = random_instr();
        pc = next_rand();
        ex_src = make_fwd_src(1'b1, exp_inst.rs0);
        mem_src = make_fwd_src(1'b1, exp_inst.rs1);
        @(negedge clk);
        check_outputs(1'b0);
    endtask

    initial begin
        #((N_CYCLES + 100) * CLK_PERIOD);
        $display("Watchdog timeout, the test did not finish in time");
        $display("Result: FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        logic [31:0] r;
        logic [31:0] ins;
        logic [31:0] add_x0;
        logic [31:0] fadd_f0;
        inst_t       e;
        rst_n = 1'b0;
        enable = 1'b1;   // A load sits on the inputs through reset.
        pc = '0;
        instr = {12'h7ff, 5'd2, 3'b010, 5'd3, LOAD};
        wb_en = 1'b0;
        wb_rd = '0;
        wb_data = '0;
        ex_src = '0;
        mem_src = '0;
        for (int i = 0; i < 64; i++) begin
            shadow[i] = 32'd0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        enable = 1'b0;
        check_val("valid_q", 32'd0, 32'(valid_q));
        check_val("inst_q control bits", 32'd0, 32'(ctrl_bits(inst_q)));
        @(negedge clk);
        check_val("valid_q", 32'd0, 32'(valid_q));
        check_val("inst_q control bits", 32'd0, 32'(ctrl_bits(inst_q)));

        add_x0 = {7'd0, 5'd0, 5'd0, 3'b000, 5'd1, OP};
        fadd_f0 = {5'b00000, 2'b00, 5'd0, 5'd0, 3'b000, 5'd1, OP_FP};   // Reads index 32.
        write_reg(6'd0, 32'hdead_beef);
        write_reg(6'd32, 32'h3f80_0000);
        for (int i = 0; i < N_WRITES; i++) begin
            r = next_rand();
            write_reg(r[13:8], next_rand());
        end
        apply_vector(add_x0, 32'h100, '0, '0);
        apply_vector(fadd_f0, 32'h104, '0, '0);
        apply_vector(add_x0, 32'h108, make_fwd_src(1'b1, 6'd0), make_fwd_src(1'b1, 6'd0));
        apply_vector(fadd_f0, 32'h10c, make_fwd_src(1'b1, 6'd32), make_fwd_src(1'b1, 6'd32));
        apply_vector(fadd_f0, 32'h110, make_fwd_src(1'b0, 6'd32), make_fwd_src(1'b1, 6'd32));
        apply_vector(fadd_f0, 32'h114, make_fwd_src(1'b0, 6'd32), '0);
        repeat (N_HOLD) hold_cycle();

        for (int i = 0; i < N_RANDOM; i++) begin
            apply_vector(random_instr(), next_rand(), '0, '0);
            r = next_rand();
            if (r[2:0] == 3'd0) begin
                hold_cycle();
            end
        end

        // Destinations aimed at the decoded sources, with regwrite random.
        for (int i = 0; i < N_FWD; i++) begin
            ins = random_instr();
            e = expect_inst(ins, 32'd0);
            r = next_rand();
            apply_vector(ins, next_rand(),
                         make_fwd_src(r[3], r[0] ? e.rs0 : e.rs1),
                         make_fwd_src(r[4], r[1] ? e.rs0 : (r[2] ? e.rs1 : r[13:8])));
            if (r[7:5] == 3'd0) begin
                write_reg(r[21:16], next_rand());
            end
        end

        if (u_decode_stage.u_decode_assert.fail_count == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("Bound assertions failed %0d times",
                     u_decode_stage.u_decode_assert.fail_count);
            $display("Result: FAILED");
            $fatal(1, "bound assertion failure");
        end
    end

endmodule
